// ==== Makefile ====
# Verilator flow for the nibble-serial rv32i core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module cpu_tb

sim:
	verilator --binary --timing -f project.f --top-module cpu_tb -Mdir obj_dir -o cpu_sim
	./obj_dir/cpu_sim | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/cpu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_control import rv_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [ram_addr_bits-1:0] mem_addr,
    output logic                     mem_we,
    output logic [xlen-1:0]          mem_wdata,
    input  logic [xlen-1:0]          mem_rdata,
    output logic [4:0]               rf_rs1,
    output logic [4:0]               rf_rs2,
    input  logic [xlen-1:0]          rf_rdata1,
    input  logic [xlen-1:0]          rf_rdata2,
    output logic                     rf_we,
    output logic [4:0]               rf_rd,
    output logic [xlen-1:0]          rf_wdata,
    output logic [xlen-1:0]          pc,
    output logic                     retire,
    output logic [xlen-1:0]          retire_pc,
    output logic                     fault
);

    state_e          state;
    logic            ph;           // second step of fetch, mem, or beq target pass
    logic [xlen-1:0] ir;
    opcode_e         opcode;
    instr_class_e    cls;
    alu_cmd_e        dec_cmd;
    alu_cmd_e        alu_cmd;
    logic [xlen-1:0] imm;
    logic            illegal;
    logic            is_shift;
    logic            tgt_pass;     // beq restarting the alu for pc + imm
    logic            taken;
    logic            alu_start;
    logic            alu_done;
    logic            alu_zero;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic            sh_start;
    logic            sh_done;
    logic [4:0]      sh_amount;
    logic [xlen-1:0] sh_result;
    logic [xlen-1:0] pc_plus4;

    instr_decode dec_i (
        .instr(ir), .opcode(opcode), .rd(rf_rd), .rs1(rf_rs1), .rs2(rf_rs2),
        .imm(imm), .alu_cmd(dec_cmd), .instr_class(cls), .illegal(illegal)
    );

    nibble_alu alu_i (
        .clk(clk), .rst_n(rst_n), .start(alu_start), .cmd(alu_cmd),
        .a(alu_a), .b(alu_b), .result(alu_result), .zero(alu_zero), .done(alu_done)
    );

    shift_loop shift_i (
        .clk(clk), .rst_n(rst_n), .start(sh_start), .cmd(dec_cmd),
        .value(rf_rdata1), .amount(sh_amount), .result(sh_result), .done(sh_done)
    );

    assign is_shift  = dec_cmd inside {alu_sll, alu_srl, alu_sra};
    assign pc_plus4  = pc + 32'd4;
    assign tgt_pass  = (cls == cls_branch) && (state == s_exec);
    assign taken     = (cls == cls_jump) || (cls == cls_branch && ph);
    assign alu_cmd   = tgt_pass ? alu_add : dec_cmd;
    assign alu_a     = (opcode == auipc || opcode == jal || tgt_pass) ? pc : rf_rdata1;
    assign alu_b     = (opcode == op || (cls == cls_branch && !tgt_pass)) ? rf_rdata2 : imm;
    assign sh_amount = (opcode == op_imm) ? imm[4:0] : rf_rdata2[4:0];   // shamt or rs2

    // starts fire in decode, so the exec wait is the alu's own 8 cycles
    assign alu_start = (state == s_decode && !illegal && opcode != lui && !is_shift)
                    || (state == s_exec && alu_done && cls == cls_branch && !ph && alu_zero);
    assign sh_start  = (state == s_decode && !illegal && is_shift);

    assign mem_addr  = (state == s_fetch) ? pc[ram_addr_bits+1:2]
                                          : alu_result[ram_addr_bits+1:2];   // word index
    assign mem_we    = (state == s_mem) && !ph && (cls == cls_store);
    assign mem_wdata = rf_rdata2;
    assign fault     = (state == s_fault);
    assign rf_we     = (state == s_write) && (cls inside {cls_alu, cls_load, cls_upper, cls_jump});

    always_comb begin
        case (cls)
            cls_load:  rf_wdata = mem_rdata;   // still addressed in s_write
            cls_jump:  rf_wdata = pc_plus4;    // link
            cls_upper: rf_wdata = (opcode == lui) ? imm : alu_result;
            default:   rf_wdata = is_shift ? sh_result : alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == s_fetch && ph)
            ir <= mem_rdata;
        if (state == s_write)
            retire_pc <= pc;   // held until the next retire
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= s_fetch;
            ph     <= 1'b0;
            pc     <= start_addr;
            retire <= 1'b0;
        end else begin
            retire <= 1'b0;
            case (state)
                s_fetch: begin
                    ph <= !ph;              // address, then ir load
                    if (ph)
                        state <= s_decode;
                end
                s_decode: begin
                    if (illegal)
                        state <= s_fault;
                    else if (opcode == lui)
                        state <= s_write;   // no alu work
                    else if (is_shift)
                        state <= s_shift;
                    else
                        state <= s_exec;
                end
                s_exec: begin
                    if (alu_done) begin
                        if (alu_start)
                            ph <= 1'b1;     // beq equal, now the target
                        else if (cls == cls_load || cls == cls_store)
                            state <= s_mem;
                        else
                            state <= s_write;
                    end
                end
                s_shift: begin
                    if (sh_done)
                        state <= s_write;
                end
                s_mem: begin
                    ph <= !ph;              // access, then data valid
                    if (ph)
                        state <= s_write;
                end
                s_write: begin
                    pc     <= taken ? {alu_result[xlen-1:1], 1'b0} : pc_plus4;
                    retire <= 1'b1;
                    ph     <= 1'b0;
                    state  <= s_fetch;
                end
                s_fault: state <= s_fault;  // until reset
                s_reset: state <= s_fetch;
                default: state <= s_reset;  // stray encodings recover
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top import rv_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     preload_we,
    input  logic [ram_addr_bits-1:0] preload_addr,
    input  logic [xlen-1:0]          preload_data,
    input  logic [4:0]               dbg_reg_sel,
    output logic [xlen-1:0]          dbg_reg_data,
    output logic [xlen-1:0]          pc,
    output logic                     retire,
    output logic [xlen-1:0]          retire_pc,
    output logic                     fault
);

    logic [ram_addr_bits-1:0] cpu_addr;
    logic                     cpu_we;
    logic [xlen-1:0]          cpu_wdata;
    logic [ram_addr_bits-1:0] ram_addr;
    logic                     ram_we;
    logic [xlen-1:0]          ram_wdata;
    logic [xlen-1:0]          ram_rdata;
    logic [4:0]               rf_rs1;
    logic [4:0]               rf_rs2;
    logic [xlen-1:0]          rf_rdata1;
    logic [xlen-1:0]          rf_rdata2;
    logic                     rf_we;
    logic [4:0]               rf_rd;
    logic [xlen-1:0]          rf_wdata;

    // preload owns the ram while reset is held
    assign ram_addr  = rst_n ? cpu_addr  : preload_addr;
    assign ram_we    = rst_n ? cpu_we    : preload_we;
    assign ram_wdata = rst_n ? cpu_wdata : preload_data;

    cpu_control ctrl_i (
        .clk(clk), .rst_n(rst_n),
        .mem_addr(cpu_addr), .mem_we(cpu_we), .mem_wdata(cpu_wdata), .mem_rdata(ram_rdata),
        .rf_rs1(rf_rs1), .rf_rs2(rf_rs2), .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .rf_we(rf_we), .rf_rd(rf_rd), .rf_wdata(rf_wdata),
        .pc(pc), .retire(retire), .retire_pc(retire_pc), .fault(fault)
    );

    register_file rf_i (
        .clk(clk), .rs1(rf_rs1), .rs2(rf_rs2), .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .rd(rf_rd), .wdata(rf_wdata),
        .dbg_sel(dbg_reg_sel), .dbg_data(dbg_reg_data)
    );

    unified_ram ram_i (
        .clk(clk), .addr(ram_addr), .we(ram_we), .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode import rv_pkg::*; (
    input  logic [xlen-1:0] instr,
    output opcode_e         opcode,
    output logic [4:0]      rd,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [xlen-1:0] imm,
    output alu_cmd_e        alu_cmd,
    output instr_class_e    instr_class,
    output logic            illegal
);

    logic [2:0]      funct3;
    logic            f7_zero;       // funct7 all zero
    logic            f7_alt;        // funct7 0100000, sub and sra
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign opcode  = opcode_e'(instr[6:0]);   // unknown codes fall to default below
    assign rd      = instr[11:7];
    assign rs1     = instr[19:15];
    assign rs2     = instr[24:20];
    assign funct3  = instr[14:12];
    assign f7_zero = (instr[31:25] == 7'b0000000);
    assign f7_alt  = (instr[31:25] == 7'b0100000);

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        imm         = imm_i;            // most common form
        alu_cmd     = alu_add;          // address and target sums
        instr_class = cls_alu;
        illegal     = 1'b0;
        case (opcode)
            op_imm: begin
                case (funct3)
                    3'b000:  alu_cmd = alu_add;
                    3'b001:  alu_cmd = alu_sll;
                    3'b101:  alu_cmd = f7_alt ? alu_sra : alu_srl;
                    default: illegal = 1'b1;   // slti, xori and friends left out
                endcase
                if (funct3 != 3'b000 && !(f7_zero || (f7_alt && funct3 == 3'b101)))
                    illegal = 1'b1;            // bad shift encoding
            end
            op: begin
                case (funct3)
                    3'b000:  alu_cmd = f7_alt ? alu_sub : alu_add;
                    3'b001:  alu_cmd = alu_sll;
                    3'b100:  alu_cmd = alu_xor;
                    3'b101:  alu_cmd = f7_alt ? alu_sra : alu_srl;
                    3'b110:  alu_cmd = alu_or;
                    3'b111:  alu_cmd = alu_and;
                    default: illegal = 1'b1;   // slt, sltu
                endcase
                if (!(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))))
                    illegal = 1'b1;
            end
            load: begin
                instr_class = cls_load;
                illegal     = (funct3 != 3'b010);   // lw only
            end
            store: begin
                instr_class = cls_store;
                imm         = imm_s;
                illegal     = (funct3 != 3'b010);   // sw only
            end
            lui, auipc: begin
                instr_class = cls_upper;
                imm         = imm_u;
            end
            jal: begin
                instr_class = cls_jump;
                imm         = imm_j;
            end
            jalr: begin
                instr_class = cls_jump;
                illegal     = (funct3 != 3'b000);
            end
            branch: begin
                instr_class = cls_branch;
                imm         = imm_b;
                alu_cmd     = alu_sub;              // compare pass
                illegal     = (funct3 != 3'b000);   // beq only
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/nibble_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module nibble_alu import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  alu_cmd_e        cmd,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result,
    output logic            zero,
    output logic            done
);

    alu_cmd_e        cmd_q;
    alu_cmd_e        cur_cmd;
    logic [xlen-1:0] a_q;          // operands, shifted down a nibble per step
    logic [xlen-1:0] b_q;
    logic [xlen-1:0] b_eff;        // b, inverted for sub
    logic            carry_q;
    logic            carry_in;
    logic            busy;
    logic [2:0]      cnt;          // index of the nibble in work
    logic [3:0]      na;
    logic [3:0]      nb;
    logic [3:0]      nib;
    logic [4:0]      sum;

    // nibble 0 is taken straight from the inputs on the start cycle
    assign b_eff    = (cmd == alu_sub) ? ~b : b;
    assign cur_cmd  = start ? cmd : cmd_q;
    assign na       = start ? a[3:0] : a_q[3:0];
    assign nb       = start ? b_eff[3:0] : b_q[3:0];
    assign carry_in = start ? (cmd == alu_sub) : carry_q;   // +1 completes two's complement
    assign sum      = {1'b0, na} + {1'b0, nb} + {4'b0, carry_in};
    assign zero     = (result == '0);                       // valid with done

    always_comb begin
        case (cur_cmd)
            alu_and: nib = na & nb;
            alu_or:  nib = na | nb;
            alu_xor: nib = na ^ nb;
            default: nib = sum[3:0];   // add and sub
        endcase
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            result  <= {nib, result[xlen-1:4]};   // fills from the top, lsb nibble first
            carry_q <= sum[4];
        end
        if (start) begin
            a_q   <= {4'b0, a[xlen-1:4]};
            b_q   <= {4'b0, b_eff[xlen-1:4]};
            cmd_q <= cmd;
        end else if (busy) begin
            a_q <= a_q >> 4;
            b_q <= b_q >> 4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= 3'd1;
            end else if (busy) begin
                cnt <= cnt + 3'd1;
                if (cnt == 3'd7) begin   // last nibble this cycle
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import rv_pkg::*; (
    input  logic            clk,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2,
    input  logic            we,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] wdata,
    input  logic [4:0]      dbg_sel,
    output logic [xlen-1:0] dbg_data
);

    logic [xlen-1:0] regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0)
            regs[rd] <= wdata;
    end

    assign rdata1   = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2   = (rs2 == 5'd0) ? '0 : regs[rs2];
    assign dbg_data = (dbg_sel == 5'd0) ? '0 : regs[dbg_sel];   // debug peek, no timing

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int xlen          = 32;              // data width
    localparam int ram_addr_bits = 10;              // 1024 words, 4 KiB byte space
    localparam logic [xlen-1:0] start_addr = 32'h0000_0204;  // first fetch after reset

    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        load   = 7'b0000011,
        store  = 7'b0100011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_sra
    } alu_cmd_e;

    typedef enum logic [3:0] {
        s_reset, s_fetch, s_decode, s_exec, s_shift, s_mem, s_write, s_fault
    } state_e;

    typedef enum logic [2:0] {
        cls_alu, cls_load, cls_store, cls_upper, cls_jump, cls_branch
    } instr_class_e;

endpackage

`default_nettype wire

// ==== design/shift_loop.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_loop import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  alu_cmd_e        cmd,
    input  logic [xlen-1:0] value,
    input  logic [4:0]      amount,
    output logic [xlen-1:0] result,
    output logic            done
);

    alu_cmd_e        cmd_q;
    logic [xlen-1:0] data_q;
    logic [4:0]      cnt;          // bits still to move
    logic            busy;

    assign result = data_q;
    assign done   = busy && (cnt == 5'd0);   // one cycle, busy drops on the same edge

    always_ff @(posedge clk) begin
        if (start) begin
            data_q <= value;
            cmd_q  <= cmd;
        end else if (busy && cnt != 5'd0) begin
            case (cmd_q)
                alu_sll: data_q <= {data_q[xlen-2:0], 1'b0};
                alu_sra: data_q <= {data_q[xlen-1], data_q[xlen-1:1]};   // sign refill
                default: data_q <= {1'b0, data_q[xlen-1:1]};             // srl
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= amount;
        end else if (busy) begin
            if (cnt == 5'd0)
                busy <= 1'b0;
            else
                cnt <= cnt - 5'd1;
        end
    end

endmodule

`default_nettype wire

// ==== design/unified_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module unified_ram import rv_pkg::*; (
    input  logic                     clk,
    input  logic [ram_addr_bits-1:0] addr,
    input  logic                     we,
    input  logic [xlen-1:0]          wdata,
    output logic [xlen-1:0]          rdata
);

    logic [xlen-1:0] mem [0:(1 << ram_addr_bits) - 1];   // code and data share it

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];   // old word on a write cycle
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+test
design/rv_pkg.sv
design/instr_decode.sv
design/nibble_alu.sv
design/shift_loop.sv
design/register_file.sv
design/unified_ram.sv
design/cpu_control.sv
design/cpu_top.sv
test/cpu_tb.sv

// ==== test/tb_encode.svh ====
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};   // sw
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};   // beq
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
        input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

logic [xlen-1:0] shadow_reg [0:31];
logic [xlen-1:0] shadow_mem [0:1023];   // word view of the 4 KiB space
bit              written [0:31];        // registers the model has set
logic [xlen-1:0] ref_pc;
logic [xlen-1:0] exp_pc [$];            // expected retire sequence
logic [4:0]      exp_rd [$];
logic [xlen-1:0] exp_val [$];

// rv32i integer ops by funct3, alt picks sub or sra
function automatic logic [xlen-1:0] op_result(input logic [2:0] f3, input bit alt,
        input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd4:    return a ^ b;
        3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// one instruction at ref_pc against the shadow state
task automatic model_step(output bit illegal_op);
    logic [xlen-1:0] ins;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] ea;        // byte address of a load or store
    logic [xlen-1:0] res;
    logic [xlen-1:0] next_pc;
    logic [4:0]      rd;
    bit              wr;
    ins        = shadow_mem[ref_pc[11:2]];
    a          = shadow_reg[ins[19:15]];
    b          = shadow_reg[ins[24:20]];
    imm_i      = {{20{ins[31]}}, ins[31:20]};
    rd         = ins[11:7];
    next_pc    = ref_pc + 32'd4;
    res        = '0;
    wr         = 1'b1;
    illegal_op = 1'b0;
    case (ins[6:0])
        op_imm: res = op_result(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i);
        op:     res = op_result(ins[14:12], ins[30], a, b);
        load: begin
            ea  = a + imm_i;
            res = shadow_mem[ea[11:2]];
        end
        store: begin
            ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            shadow_mem[ea[11:2]] = b;
            wr = 1'b0;
        end
        lui:   res = {ins[31:12], 12'b0};
        auipc: res = ref_pc + {ins[31:12], 12'b0};
        jal: begin
            res     = next_pc;   // link
            next_pc = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        jalr: begin
            res     = next_pc;
            next_pc = (a + imm_i) & ~32'd1;
        end
        branch: begin
            wr = 1'b0;
            if (a == b)
                next_pc = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        default: illegal_op = 1'b1;   // core should fault here
    endcase
    if (!illegal_op) begin
        if (wr && rd != 5'd0) begin
            shadow_reg[rd] = res;
            written[rd]    = 1'b1;
        end
        if (!written[rd])
            rd = 5'd0;                        // no known value to compare against
        exp_pc.push_back(ref_pc);
        exp_rd.push_back(rd);                 // destination, or the untouched rd field of sw and beq
        exp_val.push_back(shadow_reg[rd]);
        ref_pc = next_pc;
    end
endtask

`endif

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import rv_pkg::*; ();

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     preload_we;
    logic [ram_addr_bits-1:0] preload_addr;
    logic [xlen-1:0]          preload_data;
    logic [4:0]               dbg_reg_sel;
    logic [xlen-1:0]          dbg_reg_data;
    logic [xlen-1:0]          pc;
    logic                     retire;
    logic [xlen-1:0]          retire_pc;
    logic                     fault;

    integer                   seed = 32'he38c;
    logic [xlen-1:0]          code_pc;            // byte address of the next code word
    logic [ram_addr_bits-1:0] seg_addr [$];       // preload list for the next reset
    logic [xlen-1:0]          seg_data [$];
    logic [xlen-1:0]          r1;
    logic [xlen-1:0]          r2;
    logic [xlen-1:0]          r4;                 // forced negative for sra
    logic [xlen-1:0]          r_lui;
    logic [xlen-1:0]          r_mem;
    logic [xlen-1:0]          r_sh;

    `include "tb_encode.svh"

    cpu_top cpu_top_i (
        .clk(clk), .rst_n(rst_n),
        .preload_we(preload_we), .preload_addr(preload_addr), .preload_data(preload_data),
        .dbg_reg_sel(dbg_reg_sel), .dbg_reg_data(dbg_reg_data),
        .pc(pc), .retire(retire), .retire_pc(retire_pc), .fault(fault)
    );

    always #4 clk = ~clk;   // 8 ns period

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic expect_equal(input logic [xlen-1:0] got, input logic [xlen-1:0] want,
            input string what);
        assert (got === want)
        else report_failure($sformatf("Error at %0t: %s is %h, expected %h",
                                      $time, what, got, want));
    endtask

    task automatic put(input logic [xlen-1:0] word);
        seg_addr.push_back(code_pc[ram_addr_bits+1:2]);
        seg_data.push_back(word);
        shadow_mem[code_pc[11:2]] = word;
        code_pc = code_pc + 32'd4;
    endtask

    task automatic put_data(input logic [xlen-1:0] byte_addr, input logic [xlen-1:0] word);
        seg_addr.push_back(byte_addr[ram_addr_bits+1:2]);
        seg_data.push_back(word);
        shadow_mem[byte_addr[11:2]] = word;
    endtask

    // lui then addi, upper part rounded for the signed low 12 bits
    task automatic load_const(input logic [4:0] rd, input logic [xlen-1:0] val);
        put(u_type(val[31:12] + {19'b0, val[11]}, rd, lui));
        put(i_type(val[11:0], rd, 3'b000, rd, op_imm));
    endtask

    task automatic load_segment();
        int i;
        assert (seg_addr.size() <= 8)
        else report_failure("A program segment does not fit in the 8 reset cycles.");
        rst_n = 1'b0;
        for (i = 0; i < 8; i++) begin
            preload_we   = (i < seg_addr.size());   // one word per reset cycle
            preload_addr = (i < seg_addr.size()) ? seg_addr[i] : '0;
            preload_data = (i < seg_addr.size()) ? seg_data[i] : '0;
            @(negedge clk);
        end
        preload_we = 1'b0;
        rst_n      = 1'b1;
        seg_addr.delete();
        seg_data.delete();
    endtask

    task automatic wait_retire();
        int n;
        for (n = 0; n < 500; n++) begin
            @(negedge clk);
            if (retire)
                return;
        end
        report_failure("The core stalled: no instruction retired within 500 cycles.");
    endtask

    task automatic check_fault_hold();
        int n;
        for (n = 0; n < 500 && !fault; n++)
            @(negedge clk);
        assert (fault)
        else report_failure("The core never raised fault on the illegal opcode.");
        for (n = 0; n < 500; n++) begin
            @(negedge clk);
            assert (!retire && fault)
            else report_failure($sformatf("Error at %0t: retire or fault changed after fault",
                                          $time));
        end
    endtask

    // model the segment, reset and preload, then follow every retire
    task automatic run_segment();
        bit stop;
        int k;
        stop   = 1'b0;
        ref_pc = start_addr;
        exp_pc.delete();
        exp_rd.delete();
        exp_val.delete();
        for (k = 0; k < 64 && !stop && ref_pc != code_pc; k++)
            model_step(stop);
        load_segment();
        expect_equal(pc, start_addr, "pc after reset");
        expect_equal(32'(fault), '0, "fault after reset");
        foreach (exp_pc[i]) begin
            wait_retire();
            expect_equal(retire_pc, exp_pc[i], "retire_pc");
            dbg_reg_sel = exp_rd[i];
            @(negedge clk);             // next write is a fetch away
            expect_equal(dbg_reg_data, exp_val[i], $sformatf("x%0d", exp_rd[i]));
        end
        if (stop)
            check_fault_hold();
        code_pc = start_addr;
    endtask

    initial begin
        int r;
        rst_n        = 1'b0;
        preload_we   = 1'b0;
        preload_addr = '0;
        preload_data = '0;
        dbg_reg_sel  = '0;
        for (r = 0; r < 32; r++) begin
            shadow_reg[r] = '0;
            written[r]    = (r == 0);
        end
        code_pc = start_addr;
        r1      = $random(seed);
        r2      = $random(seed);
        r4      = $random(seed) | 32'h8000_0000;
        r_lui   = $random(seed);
        r_mem   = $random(seed);
        r_sh    = $random(seed);

        load_const(1, r1);
        load_const(2, r2);
        load_const(3, 32'h0fff_ffff);   // +1 ripples through seven nibbles
        load_const(4, r4);
        run_segment();

        put(r_type(7'h00, 2, 1, 3'b000, 5));    // add
        put(r_type(7'h20, 2, 1, 3'b000, 6));    // sub
        put(r_type(7'h00, 2, 1, 3'b111, 7));    // and
        put(r_type(7'h00, 2, 1, 3'b110, 8));    // or
        put(r_type(7'h00, 2, 1, 3'b100, 9));    // xor
        put(i_type(12'd1, 3, 3'b000, 10, op_imm));
        put(r_type(7'h00, 4, 3, 3'b000, 11));
        put(r_type(7'h20, 1, 0, 3'b000, 12));   // negate
        run_segment();

        put(i_type(12'h7ff, 0, 3'b000, 13, op_imm));
        put(i_type(12'h800, 0, 3'b000, 14, op_imm));   // -2048
        put(u_type(r_lui[19:0], 16, lui));
        put(u_type(20'h12345, 17, auipc));
        put(i_type(12'd7, 1, 3'b000, 0, op_imm));      // x0 stays zero
        put(u_type(20'habcde, 0, lui));
        put(i_type(12'd2, 0, 3'b000, 20, op_imm));
        put(i_type(12'd31, 0, 3'b000, 21, op_imm));
        run_segment();

        put(i_type({7'h00, 5'd0}, 1, 3'b001, 22, op_imm));
        put(i_type({7'h00, 5'd2}, 1, 3'b001, 23, op_imm));
        put(i_type({7'h00, 5'd31}, 1, 3'b001, 24, op_imm));
        put(i_type({7'h00, 5'd2}, 4, 3'b101, 25, op_imm));
        put(i_type({7'h00, 5'd31}, 4, 3'b101, 26, op_imm));
        put(i_type({7'h20, 5'd2}, 4, 3'b101, 27, op_imm));
        put(i_type({7'h20, 5'd31}, 4, 3'b101, 28, op_imm));
        put(i_type({7'h20, r_sh[4:0]}, 4, 3'b101, 29, op_imm));
        run_segment();

        put(r_type(7'h00, 20, 1, 3'b001, 22));  // amounts from x20, x21, x0, x2
        put(r_type(7'h00, 21, 4, 3'b101, 23));
        put(r_type(7'h20, 21, 4, 3'b101, 24));
        put(r_type(7'h20, 0, 4, 3'b101, 25));
        put(r_type(7'h00, 0, 2, 3'b001, 26));
        put(r_type(7'h00, 2, 4, 3'b101, 27));
        put(r_type(7'h20, 2, 4, 3'b101, 28));
        put(r_type(7'h00, 2, 1, 3'b001, 29));
        run_segment();

        put(i_type(12'h7f0, 0, 3'b000, 30, op_imm));   // base 0x7f0
        put(s_type(12'd16, 1, 30));
        put(s_type(12'hff0, 2, 30));
        put(i_type(12'd16, 30, 3'b010, 5, load));
        put(i_type(12'hff0, 30, 3'b010, 6, load));
        put(i_type(12'h110, 30, 3'b010, 7, load));     // untouched word at 0x900
        put_data(32'h0000_0900, r_mem);
        run_segment();

        put(j_type(21'd8, 10));
        put(i_type(12'hfff, 0, 3'b000, 31, op_imm));   // skipped by jal
        put(i_type(12'd12, 10, 3'b000, 11, jalr));
        put(i_type(12'hfff, 0, 3'b000, 31, op_imm));   // skipped by jalr
        put(b_type(13'd8, 1, 1));                      // taken
        put(i_type(12'hfff, 0, 3'b000, 31, op_imm));   // skipped by beq
        put(b_type(13'd8, 14, 13));                    // not taken
        put(i_type(12'd5, 0, 3'b000, 31, op_imm));
        run_segment();

        put(i_type(12'd1, 0, 3'b000, 5, op_imm));
        put(32'h0000_000b);                            // custom-0, unsupported
        put(i_type(12'd1, 0, 3'b000, 6, op_imm));
        run_segment();

        for (r = 0; r < 32; r++) begin
            if (written[r]) begin
                dbg_reg_sel = 5'(r);
                @(negedge clk);
                expect_equal(dbg_reg_data, shadow_reg[r], $sformatf("final x%0d", r));
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
